// ==== files.f ====
src/permAccelPkg.sv
src/resultBusIf.sv
src/syncFifo.sv
src/topManager.sv
src/botPipeline.sv
src/resultCollector.sv
src/permAccelerator.sv
tb/permAcceleratorTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module permAcceleratorTb -f files.f -o simPermAccel

./obj_dir/simPermAccel > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation ended without a pass report"
    exit 1
fi

// ==== src/botPipeline.sv ====
`timescale 1ns/10ps
`default_nettype none

module botPipeline (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                writeBot,
    input  logic [permAccelPkg::WORD_WIDTH-1:0] bot,
    input  logic [permAccelPkg::WORD_WIDTH-1:0] top,
    output logic                                ready,
    output logic                                pipelineEmpty,
    output logic [2:0]                          activity,
    resultBusIf.producer                        result
);
    import permAccelPkg::*;

    logic [PIPE_STAGES-1:0] stageValid;

    // Stage 1, AND and sum operands
    logic [WORD_WIDTH-1:0] andBits;
    logic [SUM_WIDTH-1:0] botLow;
    logic [SUM_WIDTH-1:0] topLow;
    // Stage 2, ones per byte
    logic [3:0] chunkCount [WORD_WIDTH/8];
    logic [SUM_WIDTH-1:0] sumS2;
    // Stage 3, ones per 32-bit group
    logic [5:0] groupCount [WORD_WIDTH/32];
    logic [SUM_WIDTH-1:0] sumS3;
    // Stage 4, total
    logic [7:0] totalCount;
    logic [SUM_WIDTH-1:0] sumS4;
    // Stage 5, output register
    logic [COUNT_WIDTH-1:0] countOut;
    logic [SUM_WIDTH-1:0] sumOut;

    function automatic logic [3:0] popCount8(input logic [7:0] bits);
        logic [3:0] ones;
        ones = '0;
        for (int i = 0; i < 8; i++) begin
            ones = ones + 4'(bits[i]);
        end
        return ones;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[PIPE_STAGES-2:0], writeBot};
        end
    end

    always_ff @(posedge clk) begin
        andBits <= bot & top;
        botLow <= bot[SUM_WIDTH-1:0];
        topLow <= top[SUM_WIDTH-1:0];

        for (int c = 0; c < WORD_WIDTH / 8; c++) begin
            chunkCount[c] <= popCount8(andBits[c*8 +: 8]);
        end
        // Wraps modulo 2^48
        sumS2 <= botLow + topLow;

        for (int g = 0; g < WORD_WIDTH / 32; g++) begin
            groupCount[g] <= 6'(chunkCount[4*g]) + 6'(chunkCount[4*g+1])
                           + 6'(chunkCount[4*g+2]) + 6'(chunkCount[4*g+3]);
        end
        sumS3 <= sumS2;

        totalCount <= 8'(groupCount[0]) + 8'(groupCount[1])
                    + 8'(groupCount[2]) + 8'(groupCount[3]);
        sumS4 <= sumS3;

        countOut <= COUNT_WIDTH'(totalCount);
        sumOut <= sumS4;
    end

    // Number of stages holding a bot
    always_comb begin
        activity = '0;
        for (int s = 0; s < PIPE_STAGES; s++) begin
            activity = activity + 3'(stageValid[s]);
        end
    end

    assign pipelineEmpty = (activity == '0);
    assign ready = !result.slowDown;

    assign result.valid = stageValid[PIPE_STAGES-1];
    assign result.count = countOut;
    assign result.sum = sumOut;

endmodule

`default_nettype wire

// ==== src/permAccelPkg.sv ====
`default_nettype none

package permAccelPkg;

    // Host side word widths
    localparam int WORD_WIDTH = 128;
    localparam int OUT_WIDTH = 64;

    // Bot result payload, count in the upper bits
    localparam int COUNT_WIDTH = 13;
    localparam int SUM_WIDTH = 48;
    localparam int RESULT_WIDTH = COUNT_WIDTH + SUM_WIDTH;

    // Fixed latency of the bot pipeline
    localparam int PIPE_STAGES = 5;

    // oready held low this long after rst falls
    localparam int RESET_CYCLES = 30;

    // Origin queue keeps host input order
    localparam int ORIGIN_DEPTH_LOG2 = 6;
    localparam int ORIGIN_AF_MARGIN = 8;

    // Margin covers every bot still in flight when slowDown rises
    localparam int RESULT_DEPTH_LOG2 = 5;
    localparam int RESULT_AF_MARGIN = PIPE_STAGES + 2;

    // Host output FIFO
    localparam int HOST_DEPTH_LOG2 = 4;
    localparam int HOST_AF_MARGIN = 6;

    // Grab to output strobe inside the collector
    localparam int COLLECT_LATENCY = 2;

    typedef enum logic {
        originTop = 1'b0,
        originBot = 1'b1
    } originType;

endpackage

`default_nettype wire

// ==== src/permAccelerator.sv ====
`timescale 1ns/10ps
`default_nettype none

module permAccelerator (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                ivalid,
    input  logic                                iready,
    input  logic                                startNewTop,
    input  logic [permAccelPkg::WORD_WIDTH-1:0] wordIn,
    output logic                                ovalid,
    output logic                                oready,
    output logic [permAccelPkg::OUT_WIDTH-1:0]  dataOut
);
    import permAccelPkg::*;

    logic [$clog2(RESET_CYCLES + 1)-1:0] resetCount;
    logic resetDone;

    logic writeTop;
    logic writeBot;
    logic stall;
    logic [WORD_WIDTH-1:0] top;
    logic pipeReady;
    logic pipelineEmpty;
    logic [2:0] activity;
    logic collectorReady;
    logic collectValid;
    logic [RESULT_WIDTH-1:0] collectData;
    logic hostAlmostFull;
    logic hostAlmostFullD;
    logic hostEmpty;

    resultBusIf resultBus ();

    // Keep the host out for a while after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            resetCount <= '0;
            resetDone <= 1'b0;
        end else if (int'(resetCount) == RESET_CYCLES) begin
            resetDone <= 1'b1;
        end else begin
            resetCount <= resetCount + 1'b1;
        end
    end

    assign oready = resetDone && pipeReady && !stall && collectorReady;
    assign writeTop = ivalid && oready && startNewTop;
    assign writeBot = ivalid && oready && !startNewTop;

    topManager topMngr (
        .clk(clk),
        .rst(rst),
        .writeTop(writeTop),
        .topIn(wordIn),
        .pipelineEmpty(pipelineEmpty),
        .stall(stall),
        .top(top)
    );

    botPipeline botPipe (
        .clk(clk),
        .rst(rst),
        .writeBot(writeBot),
        .bot(wordIn),
        .top(top),
        .ready(pipeReady),
        .pipelineEmpty(pipelineEmpty),
        .activity(activity),
        .result(resultBus.producer)
    );

    // Registered almostFull, the host FIFO margin covers the extra cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            hostAlmostFullD <= 1'b0;
        end else begin
            hostAlmostFullD <= hostAlmostFull;
        end
    end

    resultCollector collector (
        .clk(clk),
        .rst(rst),
        .writeTop(writeTop),
        .writeBot(writeBot),
        .activity(activity),
        .hold(hostAlmostFullD),
        .ready(collectorReady),
        .outValid(collectValid),
        .outData(collectData),
        .result(resultBus.consumer)
    );

    // Error bit and two spare bits are always zero
    syncFifo #(
        .WIDTH(OUT_WIDTH),
        .DEPTH_LOG2(HOST_DEPTH_LOG2),
        .AF_MARGIN(HOST_AF_MARGIN)
    ) hostFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(collectValid),
        .dataIn({1'b0, 2'b00, collectData}),
        .readEnable(iready && !hostEmpty),
        .dataOut(dataOut),
        .empty(hostEmpty),
        .full(),
        .almostFull(hostAlmostFull)
    );

    assign ovalid = !hostEmpty;

endmodule

`default_nettype wire

// ==== src/resultBusIf.sv ====
`timescale 1ns/10ps
`default_nettype none

// Bot results from the pipeline into the collector
interface resultBusIf;
    import permAccelPkg::*;

    logic valid;
    logic [COUNT_WIDTH-1:0] count;
    logic [SUM_WIDTH-1:0] sum;
    // Only stops new bots, results in flight still arrive
    logic slowDown;

    modport producer (
        output valid,
        output count,
        output sum,
        input  slowDown
    );

    modport consumer (
        input  valid,
        input  count,
        input  sum,
        output slowDown
    );

endinterface

`default_nettype wire

// ==== src/resultCollector.sv ====
`timescale 1ns/10ps
`default_nettype none

module resultCollector (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  writeTop,
    input  logic                                  writeBot,
    input  logic [2:0]                            activity,
    input  logic                                  hold,
    output logic                                  ready,
    output logic                                  outValid,
    output logic [permAccelPkg::RESULT_WIDTH-1:0] outData,
    resultBusIf.consumer                          result
);
    import permAccelPkg::*;

    logic originDataOut;
    originType originHead;
    originType originIn;
    logic originEmpty;
    logic originFull;
    logic originAlmostFull;

    logic [RESULT_WIDTH-1:0] resultData;
    logic resultEmpty;
    logic resultAlmostFull;

    logic headIsTop;
    logic grab;

    // Profiling since the previous top
    logic [29:0] activityCounter;
    logic [30:0] clockCounter;
    logic [RESULT_WIDTH-1:0] topRecord;

    logic [COLLECT_LATENCY-1:0] validPipe;
    logic [RESULT_WIDTH-1:0] dataPipe [COLLECT_LATENCY];

    assign originIn = writeTop ? originTop : originBot;

    syncFifo #(
        .WIDTH(1),
        .DEPTH_LOG2(ORIGIN_DEPTH_LOG2),
        .AF_MARGIN(ORIGIN_AF_MARGIN)
    ) originQueue (
        .clk(clk),
        .rst(rst),
        .writeEnable(writeTop || writeBot),
        .dataIn(originIn),
        .readEnable(grab),
        .dataOut(originDataOut),
        .empty(originEmpty),
        .full(originFull),
        .almostFull(originAlmostFull)
    );

    // Every result is taken, slowDown only throttles new bots
    syncFifo #(
        .WIDTH(RESULT_WIDTH),
        .DEPTH_LOG2(RESULT_DEPTH_LOG2),
        .AF_MARGIN(RESULT_AF_MARGIN)
    ) resultFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(result.valid),
        .dataIn({result.count, result.sum}),
        .readEnable(grab && !headIsTop),
        .dataOut(resultData),
        .empty(resultEmpty),
        .full(),
        .almostFull(resultAlmostFull)
    );

    assign result.slowDown = resultAlmostFull;
    assign ready = !originAlmostFull;

    assign originHead = originType'(originDataOut);
    assign headIsTop = (originHead == originTop);
    // A bot waits at the head until its result has arrived
    assign grab = !originEmpty && !hold && (headIsTop || !resultEmpty);

    assign topRecord = {activityCounter, clockCounter};

    always_ff @(posedge clk) begin
        if (rst) begin
            clockCounter <= '0;
            activityCounter <= '0;
        end else if (grab && headIsTop) begin
            // Next count period starts with the grab cycle itself
            clockCounter <= 31'd1;
            activityCounter <= 30'(activity);
        end else begin
            clockCounter <= clockCounter + 31'd1;
            activityCounter <= activityCounter + 30'(activity);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= grab;
            for (int i = 1; i < COLLECT_LATENCY; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        dataPipe[0] <= headIsTop ? topRecord : resultData;
        for (int i = 1; i < COLLECT_LATENCY; i++) begin
            dataPipe[i] <= dataPipe[i-1];
        end
    end

    assign outValid = validPipe[COLLECT_LATENCY-1];
    assign outData = dataPipe[COLLECT_LATENCY-1];

    // ready must have throttled the host well before the queue fills
    assert property (@(posedge clk) disable iff (rst) !(originFull && (writeTop || writeBot)))
        else $error("origin queue written while full");

endmodule

`default_nettype wire

// ==== src/syncFifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH_LOG2 = 4,
    parameter int AF_MARGIN = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             writeEnable,
    input  logic [WIDTH-1:0] dataIn,
    input  logic             readEnable,
    output logic [WIDTH-1:0] dataOut,
    output logic             empty,
    output logic             full,
    output logic             almostFull
);

    logic [WIDTH-1:0] mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0] writePtr;
    logic [DEPTH_LOG2-1:0] readPtr;
    // One extra bit so a full FIFO is distinct from an empty one
    logic [DEPTH_LOG2:0] count;

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            count <= '0;
        end else begin
            if (writeEnable) begin
                writePtr <= writePtr + 1'b1;
            end
            if (readEnable) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({writeEnable, readEnable})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head word is visible without a read request
    assign dataOut = mem[readPtr];
    assign empty = (count == '0);
    assign full = count[DEPTH_LOG2];
    assign almostFull = (count >= (DEPTH_LOG2 + 1)'(2**DEPTH_LOG2 - AF_MARGIN));

    assert property (@(posedge clk) disable iff (rst) !(writeEnable && full))
        else $error("syncFifo written while full");

    assert property (@(posedge clk) disable iff (rst) !(readEnable && empty))
        else $error("syncFifo read while empty");

endmodule

`default_nettype wire

// ==== src/topManager.sv ====
`timescale 1ns/10ps
`default_nettype none

module topManager (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              writeTop,
    input  logic [permAccelPkg::WORD_WIDTH-1:0] topIn,
    input  logic                              pipelineEmpty,
    output logic                              stall,
    output logic [permAccelPkg::WORD_WIDTH-1:0] top
);
    import permAccelPkg::*;

    logic [WORD_WIDTH-1:0] pendingTop;
    logic pending;

    // Holds the deferred top until the last bot of the old one has left
    always_ff @(posedge clk) begin
        if (writeTop) begin
            pendingTop <= topIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            top <= '0;
        end else if (writeTop) begin
            if (pipelineEmpty) begin
                // Nothing in flight, take the new top at once
                top <= topIn;
            end else begin
                pending <= 1'b1;
            end
        end else if (pending && pipelineEmpty) begin
            top <= pendingTop;
            pending <= 1'b0;
        end
    end

    // Registered, so oready never depends on ivalid
    assign stall = pending;

    // The top level must drop oready for as long as a top is pending
    assert property (@(posedge clk) disable iff (rst) writeTop |-> !stall)
        else $error("writeTop accepted while a previous top is pending");

endmodule

`default_nettype wire

// ==== tb/permAcceleratorTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module permAcceleratorTb;
    import permAccelPkg::*;

    localparam int NUM_WORDS = 300;
    localparam int CYCLE_LIMIT = 4 * NUM_WORDS + 500;
    localparam int LONG_PAUSE = 80;
    localparam int LONG_PAUSE_COUNT = 3;

    logic clk;
    logic rst;
    logic ivalid;
    logic iready;
    logic startNewTop;
    logic [WORD_WIDTH-1:0] wordIn;
    logic ovalid;
    logic oready;
    logic [OUT_WIDTH-1:0] dataOut;

    // Expected output words in host order
    logic [OUT_WIDTH-1:0] expWord [$];
    bit expIsTop [$];
    logic [WORD_WIDTH-1:0] refTop;

    int cycleCount;
    int receivedCount;
    int lowRun;
    bit readStarted;
    bit longPause;
    bit sawDrop;

    permAccelerator i_dut (
        .clk(clk),
        .rst(rst),
        .ivalid(ivalid),
        .iready(iready),
        .startNewTop(startNewTop),
        .wordIn(wordIn),
        .ovalid(ovalid),
        .oready(oready),
        .dataOut(dataOut)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Count of common set bits and low 48-bit sum
    function automatic logic [RESULT_WIDTH-1:0] refBotResult(
        input logic [WORD_WIDTH-1:0] botWord,
        input logic [WORD_WIDTH-1:0] topWord
    );
        logic [WORD_WIDTH-1:0] common;
        logic [COUNT_WIDTH-1:0] ones;
        logic [SUM_WIDTH-1:0] total;
        common = botWord & topWord;
        ones = '0;
        for (int i = 0; i < WORD_WIDTH; i++) begin
            if (common[i]) begin
                ones = ones + 1'b1;
            end
        end
        total = botWord[SUM_WIDTH-1:0] + topWord[SUM_WIDTH-1:0];
        return {ones, total};
    endfunction

    // All ones now and then, to hit the full count and the sum wrap
    function automatic logic [WORD_WIDTH-1:0] randomWord();
        logic [WORD_WIDTH-1:0] word;
        if ($urandom % 16 == 0) begin
            word = '1;
        end else begin
            word = {$urandom, $urandom, $urandom, $urandom};
        end
        return word;
    endfunction

    task automatic checkValue(
        input string testName,
        input logic [OUT_WIDTH-1:0] expected,
        input logic [OUT_WIDTH-1:0] actual
    );
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", testName, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic pushExpected(input bit newTop, input logic [WORD_WIDTH-1:0] word);
        if (newTop) begin
            refTop = word;
            expWord.push_back('0);
            expIsTop.push_back(1'b1);
        end else begin
            expWord.push_back({3'b000, refBotResult(word, refTop)});
            expIsTop.push_back(1'b0);
        end
    endtask

    // Holds the word until oready takes it
    task automatic sendWord(input bit newTop, input logic [WORD_WIDTH-1:0] word);
        bit accepted;
        accepted = 1'b0;
        ivalid = 1'b1;
        startNewTop = newTop;
        wordIn = word;
        while (!accepted) begin
            @(negedge clk);
            if (oready) begin
                accepted = 1'b1;
                pushExpected(newTop, word);
            end
            @(posedge clk);
            #1;
        end
        ivalid = 1'b0;
    endtask

    initial begin : mainStimulus
        bit isTop;
        logic [WORD_WIDTH-1:0] word;
        void'($urandom(32'h102c469d));
        rst = 1'b1;
        ivalid = 1'b0;
        iready = 1'b0;
        startNewTop = 1'b0;
        wordIn = '0;
        refTop = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Host is kept out right after reset
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkValue("oready low after reset", 64'd0, 64'(oready));
            checkValue("ovalid low after reset", 64'd0, 64'(ovalid));
        end
        @(posedge clk);
        #1;
        readStarted = 1'b1;

        // First word is a top, later tops often land with bots in flight
        for (int i = 0; i < NUM_WORDS; i++) begin
            isTop = (i == 0) || ($urandom % 8 == 0);
            word = randomWord();
            if ($urandom % 5 == 0) begin
                @(posedge clk);
                #1;
            end
            sendWord(isTop, word);
        end

        while (receivedCount < NUM_WORDS) begin
            @(posedge clk);
        end
        // Extra words would show up here as unexpected
        repeat (20) @(posedge clk);
        @(negedge clk);
        checkValue("no output word after the last", 64'd0, 64'(ovalid));
        checkValue("oready drop under back-pressure", 64'd1, 64'(sawDrop));
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Short random gaps and a few long pauses that fill the host FIFO
    initial begin : driveIready
        int nextPauseAt;
        int pauseIndex;
        nextPauseAt = 40;
        pauseIndex = 0;
        wait (readStarted);
        forever begin
            if (pauseIndex < LONG_PAUSE_COUNT && receivedCount >= nextPauseAt) begin
                iready = 1'b0;
                longPause = 1'b1;
                repeat (LONG_PAUSE) begin
                    @(posedge clk);
                    #1;
                end
                longPause = 1'b0;
                pauseIndex++;
                nextPauseAt = nextPauseAt + 90;
            end else begin
                iready = ($urandom % 4 != 0);
                @(posedge clk);
                #1;
            end
        end
    end

    always @(negedge clk) begin : compareOutputs
        logic [OUT_WIDTH-1:0] expected;
        bit isTop;
        logic [30:0] clockField;
        logic [29:0] activityField;
        if (!rst && ovalid && iready) begin
            if (expWord.size() == 0) begin
                $display("An output word arrived when no word was expected");
                $display("CHECKS FAILED");
                $fatal(1, "Unexpected output word");
            end else begin
                expected = expWord.pop_front();
                isTop = expIsTop.pop_front();
                checkValue("error and spare bits", 64'd0, 64'(dataOut[OUT_WIDTH-1:RESULT_WIDTH]));
                if (isTop) begin
                    clockField = dataOut[30:0];
                    activityField = dataOut[60:31];
                    checkValue("top record clock above zero", 64'd1, 64'(clockField != '0));
                    checkValue("top record activity bound", 64'd1,
                        64'(64'(activityField) <= 64'(PIPE_STAGES) * 64'(clockField)));
                end else begin
                    checkValue("bot result", expected, dataOut);
                end
                receivedCount++;
            end
        end
    end

    // A long low run on oready during a pause means the FIFOs backed up
    always @(negedge clk) begin
        if (longPause && !oready) begin
            lowRun++;
        end else begin
            lowRun = 0;
        end
        if (lowRun >= 10) begin
            sawDrop = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d of %0d words received",
                cycleCount, receivedCount, NUM_WORDS);
            $display("CHECKS FAILED");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

endmodule

`default_nettype wire
